// ==== list.f ====
+incdir+dv
hw/macPkg.sv
hw/alignIf.sv
hw/delayLine.sv
hw/mulPipe.sv
hw/macCombine.sv
hw/macAlignTop.sv
dv/tbMacAlign.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tbMacAlign -o simMacAlign
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOutput=$(./obj_dir/simMacAlign 2>&1)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qF 'All tests passed!'; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== dv/macModel.svh ====
`ifndef MAC_MODEL_SVH
`define MAC_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
localparam logic [31:0] LFSR_SEED = 32'h1ca39899;
logic [31:0] lfsrState = LFSR_SEED;

// Signed 32-bit range held in 64 bits
localparam longint SUM_MAX = 64'sh0000_0000_7fff_ffff;
localparam longint SUM_MIN = 64'shffff_ffff_8000_0000;

// Expected outputs, entry 3 is what the outputs show now
logic signed [WORD_W-1:0] expResult [4];
logic [TAG_W-1:0] expTag [4];
logic expValid [4];
logic expOvf [4];

// One LFSR step per bit taken, newest bit in the LSB
function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        lfsrState = {lfsrState[30:0],
                     lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
        value = {value[30:0], lfsrState[0]};
    end
    return value;
endfunction

function automatic void modelClear();
    for (int i = 0; i < 4; i++) begin
        expResult[i] = '0;
        expTag[i] = '0;
        expValid[i] = 1'b0;
        expOvf[i] = 1'b0;
    end
endfunction

// Enabled edge: everything moves one slot toward the outputs
function automatic void modelShift(
    input logic signed [OPER_W-1:0] x,
    input logic signed [OPER_W-1:0] y,
    input logic signed [WORD_W-1:0] z,
    input logic [TAG_W-1:0] t,
    input logic v
);
    longint sum;
    logic signed [WORD_W-1:0] satVal;
    logic clip;
    sum = longint'(x) * longint'(y) + longint'(z);
    clip = (sum > SUM_MAX) || (sum < SUM_MIN);
    if (sum > SUM_MAX) begin
        satVal = 32'sh7fff_ffff;
    end else if (sum < SUM_MIN) begin
        satVal = 32'sh8000_0000;
    end else begin
        satVal = sum[WORD_W-1:0];
    end
    for (int i = 3; i > 0; i--) begin
        expResult[i] = expResult[i-1];
        expTag[i] = expTag[i-1];
        expValid[i] = expValid[i-1];
        expOvf[i] = expOvf[i-1];
    end
    expResult[0] = v ? satVal : '0;
    expTag[0] = t;
    expValid[0] = v;
    expOvf[0] = v && clip;
endfunction

`endif

// ==== dv/tbMacAlign.sv ====
`timescale 1ns/1ps

module tbMacAlign;

    import macPkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_CYCLES = 2000;
    localparam int DRAIN_CYCLES = 8;
    localparam int CYCLE_LIMIT = RANDOM_CYCLES + 100;

    logic clk;
    logic rst;
    logic en;
    logic inValid;
    logic signed [OPER_W-1:0] a;
    logic signed [OPER_W-1:0] b;
    logic signed [WORD_W-1:0] c;
    logic [TAG_W-1:0] tag;
    logic outValid;
    logic signed [WORD_W-1:0] result;
    logic [TAG_W-1:0] outTag;
    logic overflow;

    int lowLeft = 0;
    int validSeen = 0;
    int ovfSeen = 0;
    int cycleCount = 0;

    `include "macModel.svh"

    macAlignTop dut (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .inValid  (inValid),
        .a        (a),
        .b        (b),
        .c        (c),
        .tag      (tag),
        .outValid (outValid),
        .result   (result),
        .outTag   (outTag),
        .overflow (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("Fail at %0t: %s is %h, expected %h", $time, what, got, want);
        $display("Test failures found");
        $fatal(1, "Output mismatch");
    endtask

    task automatic checkOutputs();
        assert (outValid === expValid[3])
            else reportMismatch("outValid", {31'b0, outValid}, {31'b0, expValid[3]});
        assert (overflow === expOvf[3])
            else reportMismatch("overflow", {31'b0, overflow}, {31'b0, expOvf[3]});
        assert (result === expResult[3])
            else reportMismatch("result", result, expResult[3]);
        assert (outTag === expTag[3])
            else reportMismatch("outTag", {28'b0, outTag}, {28'b0, expTag[3]});
        if (outValid) validSeen++;
        if (overflow) ovfSeen++;
    endtask

    task automatic driveRandom();
        logic [31:0] r;
        if (lowLeft > 0) begin
            en <= 1'b0;
            lowLeft--;
        end else begin
            r = randBits(2);
            en <= (r[1:0] != 2'b00);
            // Sometimes the stall runs on for a few more edges
            if (r[1:0] == 2'b00) begin
                r = randBits(3);
                lowLeft = {29'b0, r[2:0]};
            end
        end
        r = randBits(1);
        inValid <= r[0];
        r = randBits(16);
        a <= r[15:0];
        r = randBits(16);
        b <= r[15:0];
        r = randBits(3);
        if (r[2:0] == 3'b000) begin
            // Addend close to an extreme so the sum can saturate
            r = randBits(17);
            c <= r[16] ? WORD_MAX - {16'b0, r[15:0]} : WORD_MIN + {16'b0, r[15:0]};
        end else begin
            c <= randBits(32);
        end
        r = randBits(4);
        tag <= r[3:0];
    endtask

    // Model sees the same input values the DUT captures on this edge
    task automatic stepCycle(input logic nextRst, input int mode);
        @(posedge clk);
        if (rst) begin
            modelClear();
        end else if (en) begin
            modelShift(a, b, c, tag, inValid);
        end
        rst <= nextRst;
        if (mode == 1) begin
            driveRandom();
        end else if (mode == 2) begin
            en <= 1'b1;
            inValid <= 1'b0;
        end
        @(negedge clk);
        checkOutputs();
    endtask

    initial begin
        rst = 1'b1;
        en = 1'b1;
        inValid = 1'b0;
        a = '0;
        b = '0;
        c = '0;
        tag = '0;
        modelClear();
        repeat (RESET_CYCLES - 1) stepCycle(1'b1, 0);
        stepCycle(1'b0, 0);
        repeat (RANDOM_CYCLES) stepCycle(1'b0, 1);
        repeat (DRAIN_CYCLES) stepCycle(1'b0, 2);
        if (validSeen == 0 || ovfSeen == 0) begin
            $display("The stimulus never produced a valid item or a saturated sum");
            $display("Test failures found");
            $fatal(1, "Stimulus too weak");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    initial begin
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $fatal(1, "Run exceeded its cycle limit");
    end

endmodule

// ==== hw/macAlignTop.sv ====
`timescale 1ns/1ps

module macAlignTop (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               en,
    input  logic                               inValid,
    input  logic signed [macPkg::OPER_W-1:0]   a,
    input  logic signed [macPkg::OPER_W-1:0]   b,
    input  logic signed [macPkg::WORD_W-1:0]   c,
    input  logic [macPkg::TAG_W-1:0]           tag,
    output logic                               outValid,
    output logic signed [macPkg::WORD_W-1:0]   result,
    output logic [macPkg::TAG_W-1:0]           outTag,
    output logic                               overflow
);

    import macPkg::*;

    // Addend and tag packed for the sideband delay line
    sideband_t sideIn;

    alignIf bus ();

    assign bus.en  = en;
    assign bus.rst = rst;

    assign sideIn.addend = c;
    assign sideIn.tag    = tag;

    mulPipe uMul (
        .clk (clk),
        .a   (a),
        .b   (b),
        .bus (bus)
    );

    // Both delay lines match the multiplier depth
    delayLine #(
        .PAYLOAD (sideband_t),
        .DEPTH   (MUL_STAGES)
    ) uSideDelay (
        .clk  (clk),
        .rst  (bus.rst),
        .en   (bus.en),
        .din  (sideIn),
        .dout (bus.side)
    );

    delayLine #(
        .PAYLOAD (logic),
        .DEPTH   (MUL_STAGES)
    ) uValidDelay (
        .clk  (clk),
        .rst  (bus.rst),
        .en   (bus.en),
        .din  (inValid),
        .dout (bus.valid)
    );

    macCombine uCombine (
        .clk      (clk),
        .bus      (bus),
        .result   (result),
        .outTag   (outTag),
        .outValid (outValid),
        .overflow (overflow)
    );

endmodule

// ==== hw/macCombine.sv ====
`timescale 1ns/1ps

module macCombine (
    input  logic                               clk,
    alignIf.combineSide                        bus,
    output logic signed [macPkg::WORD_W-1:0]   result,
    output logic [macPkg::TAG_W-1:0]           outTag,
    output logic                               outValid,
    output logic                               overflow
);

    import macPkg::*;

    // One extra bit so the sum cannot wrap
    logic signed [WORD_W:0] sumWide;
    logic signed [WORD_W-1:0] sumSat;
    logic clamped;

    always_comb begin
        sumWide = {bus.product[WORD_W-1], bus.product}
                + {bus.side.addend[WORD_W-1], bus.side.addend};
    end

    // Top two bits disagree when the sum leaves the 32-bit range
    always_comb begin
        clamped = sumWide[WORD_W] != sumWide[WORD_W-1];
        if (!clamped) begin
            sumSat = sumWide[WORD_W-1:0];
        end else if (sumWide[WORD_W]) begin
            sumSat = WORD_MIN;
        end else begin
            sumSat = WORD_MAX;
        end
    end

    // Output register stage
    always_ff @(posedge clk) begin
        if (bus.rst) begin
            result   <= '0;
            outTag   <= '0;
            outValid <= 1'b0;
            overflow <= 1'b0;
        end else if (bus.en) begin
            // Empty slots show a zero result
            result   <= bus.valid ? sumSat : '0;
            outTag   <= bus.side.tag;
            outValid <= bus.valid;
            overflow <= bus.valid && clamped;
        end
    end

    // A valid item meets a known product and addend
    validInputsKnown: assert property (
        @(posedge clk) disable iff (bus.rst)
        bus.en && bus.valid |-> !$isunknown({bus.product, bus.side})
    );

    // Both parallel paths hold through a stall
    pathsHoldOnStall: assert property (
        @(posedge clk)
        !bus.rst && !bus.en |=> $stable(bus.product) && $stable(bus.side) && $stable(bus.valid)
    );

endmodule

// ==== hw/mulPipe.sv ====
`timescale 1ns/1ps

module mulPipe (
    input logic                                clk,
    input logic signed [macPkg::OPER_W-1:0]    a,
    input logic signed [macPkg::OPER_W-1:0]    b,
    alignIf.mulSide                            bus
);

    import macPkg::*;

    // Stage 1 operand registers
    logic signed [OPER_W-1:0] aReg;
    logic signed [OPER_W-1:0] bReg;

    // Stage 2 partial products
    logic signed [PP_W-1:0] ppHigh;
    logic signed [PP_W-1:0] ppLow;

    // Partial products widened to the result width
    logic signed [WORD_W-1:0] highExt;
    logic signed [WORD_W-1:0] lowExt;

    always_ff @(posedge clk) begin
        if (bus.en) begin
            aReg <= a;
            bReg <= b;
        end
    end

    // Upper byte of b keeps its sign, lower byte is unsigned
    always_ff @(posedge clk) begin
        if (bus.en) begin
            ppHigh <= aReg * $signed(bReg[OPER_W-1:HALF_W]);
            ppLow  <= aReg * $signed({1'b0, bReg[HALF_W-1:0]});
        end
    end

    always_comb begin
        highExt = {{(WORD_W-PP_W){ppHigh[PP_W-1]}}, ppHigh};
        lowExt  = {{(WORD_W-PP_W){ppLow[PP_W-1]}}, ppLow};
    end

    // Stage 3 weights the upper partial product by one byte
    always_ff @(posedge clk) begin
        if (bus.en) begin
            bus.product <= (highExt <<< HALF_W) + lowExt;
        end
    end

endmodule

// ==== hw/delayLine.sv ====
`timescale 1ns/1ps

module delayLine #(
    parameter type PAYLOAD = logic,
    parameter int DEPTH = 1
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   en,
    input  PAYLOAD din,
    output PAYLOAD dout
);

    generate
        if (DEPTH == 0) begin : genPass
            // No stages, so the payload goes straight through
            assign dout = din;
        end else begin : genRegs
            PAYLOAD stages [DEPTH];

            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stages[i] <= '0;
                    end
                end else if (en) begin
                    stages[0] <= din;
                    for (int i = 1; i < DEPTH; i++) begin
                        stages[i] <= stages[i-1];
                    end
                end
            end

            // Oldest entry leaves the line
            assign dout = stages[DEPTH-1];
        end
    endgenerate

    // Once out of reset the line never emits unknown bits
    doutKnown: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(dout)
    );

endmodule

// ==== hw/alignIf.sv ====
`timescale 1ns/1ps

interface alignIf;

    import macPkg::*;

    // Multiplier output, three enabled edges after the operands
    logic signed [WORD_W-1:0] product;

    // Addend, tag and valid, delayed to line up with product
    sideband_t side;
    logic valid;

    // Pipeline controls from the top level
    logic en;
    logic rst;

    modport mulSide (
        output product,
        input  en
    );

    modport delaySide (
        output side,
        output valid,
        input  en,
        input  rst
    );

    modport combineSide (
        input product,
        input side,
        input valid,
        input en,
        input rst
    );

endinterface

// ==== hw/macPkg.sv ====
package macPkg;

    // Operand and result widths
    localparam int OPER_W = 16;
    localparam int WORD_W = 32;
    localparam int TAG_W = 4;

    // Operand b is split into two bytes for the partial products
    localparam int HALF_W = OPER_W / 2;
    localparam int PP_W = OPER_W + HALF_W;

    // Multiplier depth, which the delay lines copy
    localparam int MUL_STAGES = 3;

    // Saturation limits of the signed result
    localparam logic signed [WORD_W-1:0] WORD_MAX = {1'b0, {(WORD_W-1){1'b1}}};
    localparam logic signed [WORD_W-1:0] WORD_MIN = {1'b1, {(WORD_W-1){1'b0}}};

    // Everything that rides next to the multiplier
    typedef struct packed {
        logic signed [WORD_W-1:0] addend;
        logic [TAG_W-1:0] tag;
    } sideband_t;

endpackage
